// File: common/rls_pkg.sv
`default_nettype none

package rls_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Matrix dimension and lower-triangle entry count
	localparam int DIM = 5;
	localparam int TRI = DIM * (DIM + 1) / 2;

	// Element, accumulator and divider widths
	localparam int ELEM_W = 32;
	localparam int FRAC_W = 16;
	localparam int ACC_W = 2 * ELEM_W;
	localparam int DIV_W = 2 * ACC_W;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic signed [ELEM_W-1:0] elem_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic signed [DIV_W-1:0] wide_t;

	// Vector x, gain t, and the triangle stored row by row
	typedef elem_t vec_t [DIM];
	typedef acc_t gain_t [DIM];
	typedef elem_t tri_t [TRI];

	//////////////////////////////
	// Fixed-point constants
	//////////////////////////////

	// One in the shared Q format
	localparam acc_t FIX_ONE = acc_t'(1) <<< FRAC_W;

	// Clamp limits of an output element
	localparam elem_t ELEM_MAX = {1'b0, {(ELEM_W-1){1'b1}}};
	localparam elem_t ELEM_MIN = {1'b1, {(ELEM_W-1){1'b0}}};

	// Position of entry (row, col), row >= col, in the triangle
	function automatic int tri_index(input int row, input int col);
		return row * (row + 1) / 2 + col;
	endfunction

endpackage

`default_nettype wire

// File: divider/seq_divider.sv
`default_nettype none

module seq_divider
	import rls_pkg::*;
#(
	parameter int DIV_W = rls_pkg::DIV_W
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire wide_t dividend,
	input wire wide_t divisor,
	output logic done,
	output wide_t quotient
);

	localparam int CNT_W = $clog2(DIV_W + 1);

	// Iteration control
	logic busy;
	logic [CNT_W-1:0] cnt;

	// Operand magnitudes at start
	logic [DIV_W-1:0] num_mag;
	logic [DIV_W-1:0] den_mag;

	// Working registers
	logic [DIV_W-1:0] rem_q;
	logic [DIV_W-1:0] quo_q;
	logic [DIV_W-1:0] den_q;
	logic neg_q;

	// One restoring step
	logic [DIV_W:0] shifted;
	logic [DIV_W:0] trial;
	logic [DIV_W-1:0] rem_next;
	logic [DIV_W-1:0] quo_next;

	always_comb
	begin
		num_mag = dividend[DIV_W-1] ? -dividend : dividend;
		den_mag = divisor[DIV_W-1] ? -divisor : divisor;
	end

	//////////////////////////////
	// Restoring step
	//////////////////////////////

	always_comb
	begin
		// Bring down the next dividend bit
		shifted = {rem_q, quo_q[DIV_W-1]};
		trial = shifted - {1'b0, den_q};
		// Negative trial keeps the old remainder
		if (trial[DIV_W])
		begin
			rem_next = shifted[DIV_W-1:0];
			quo_next = {quo_q[DIV_W-2:0], 1'b0};
		end
		else
		begin
			rem_next = trial[DIV_W-1:0];
			quo_next = {quo_q[DIV_W-2:0], 1'b1};
		end
	end

	// Sequencing over DIV_W steps then done
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				cnt <= CNT_W'(DIV_W);
			end
			else if (busy)
			begin
				cnt <= cnt - 1'b1;
				if (cnt == 1)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Datapath with the sign restored on the final step
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			rem_q <= '0;
			quo_q <= num_mag;
			den_q <= den_mag;
			neg_q <= dividend[DIV_W-1] ^ divisor[DIV_W-1];
		end
		else if (busy)
		begin
			rem_q <= rem_next;
			quo_q <= quo_next;
			if (cnt == 1)
				quotient <= neg_q ? wide_t'(-quo_next) : wide_t'(quo_next);
		end
	end

	// Sequencer waits for done before the next entry
	a_no_restart: assert property (@(posedge clk) disable iff (!rst)
		start |-> !busy);

endmodule

`default_nettype wire

// File: logic/gain_vector.sv
`default_nettype none

module gain_vector
	import rls_pkg::*;
#(
	parameter int DIM = rls_pkg::DIM,
	parameter int FRAC_W = rls_pkg::FRAC_W
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic load,
	input wire tri_t p_in,
	input wire vec_t x_in,
	output gain_t gain,
	output acc_t denom
);

	// Full symmetric matrix rebuilt from the triangle
	elem_t p_full [DIM][DIM];

	// Exact dot products before scaling
	wide_t dot [DIM];
	wide_t d_sum;

	// Second stage enable one cycle behind load
	logic load_d;

	//////////////////////////////
	// Symmetric expansion
	//////////////////////////////

	always_comb
	begin
		for (int i = 0; i < DIM; i++)
		begin
			for (int j = 0; j < DIM; j++)
			begin
				// Upper half mirrors the lower half
				if (j <= i)
					p_full[i][j] = p_in[tri_index(i, j)];
				else
					p_full[i][j] = p_in[tri_index(j, i)];
			end
		end
	end

	//////////////////////////////
	// Matrix-vector product
	//////////////////////////////

	always_comb
	begin
		for (int i = 0; i < DIM; i++)
		begin
			dot[i] = '0;
			// Each product is exact in 64 bits and the sum kept wide
			for (int j = 0; j < DIM; j++)
			begin
				dot[i] = dot[i] + wide_t'(acc_t'(p_full[i][j]) * acc_t'(x_in[j]));
			end
		end
	end

	// x' * t from the registered gain
	always_comb
	begin
		d_sum = '0;
		for (int i = 0; i < DIM; i++)
		begin
			d_sum = d_sum + wide_t'(gain[i]) * wide_t'(x_in[i]);
		end
	end

	// Pipeline control
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			load_d <= 1'b0;
		else
			load_d <= load;
	end

	// Gain on load and the denominator one cycle later
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int i = 0; i < DIM; i++)
			begin
				gain[i] <= acc_t'(dot[i] >>> FRAC_W);
			end
		end
		// Add one in Q format after rescaling
		if (load_d)
			denom <= acc_t'(d_sum >>> FRAC_W) + FIX_ONE;
	end

endmodule

`default_nettype wire

// File: logic/update_sequencer.sv
`default_nettype none

module update_sequencer
	import rls_pkg::*;
#(
	parameter int DIM = rls_pkg::DIM,
	parameter int FRAC_W = rls_pkg::FRAC_W
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flag_in,
	input wire gain_t gain,
	input wire acc_t denom,
	input wire logic div_done,
	input wire wide_t quotient,
	output logic load,
	output logic div_start,
	output wide_t dividend,
	output wide_t divisor,
	output logic flag_out,
	output tri_t p_out
);

	localparam int ROW_W = (DIM > 1) ? $clog2(DIM) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_DIVIDE,
		S_FINISH
	} state_t;

	state_t state;

	// Two-stage sample of flag_in that resets to ones
	logic [1:0] flag_sr;
	logic start;

	// Current triangle entry
	logic [ROW_W-1:0] row;
	logic [ROW_W-1:0] col;
	logic last_entry;

	wide_t num_prod;
	elem_t q_sat;

	// Falling edge of flag_in is ignored while a run is active
	assign start = (flag_sr == 2'b10) && flag_out;
	assign last_entry = (row == ROW_W'(DIM - 1)) && (col == row);

	//////////////////////////////
	// Numerator and divisor
	//////////////////////////////

	always_comb
	begin
		num_prod = wide_t'(gain[row]) * wide_t'(gain[col]);
		// Drop the extra fraction then realign for the divide
		dividend = (num_prod >>> FRAC_W) <<< FRAC_W;
		divisor = wide_t'(denom);
	end

	// Clamp to element range
	always_comb
	begin
		if (quotient > wide_t'(ELEM_MAX))
			q_sat = ELEM_MAX;
		else if (quotient < wide_t'(ELEM_MIN))
			q_sat = ELEM_MIN;
		else
			q_sat = elem_t'(quotient);
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			flag_sr <= 2'b11;
			state <= S_IDLE;
			load <= 1'b0;
			div_start <= 1'b0;
			flag_out <= 1'b1;
			row <= '0;
			col <= '0;
			p_out <= '{default: '0};
		end
		else
		begin
			flag_sr <= {flag_sr[0], flag_in};
			div_start <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						flag_out <= 1'b0;
						p_out <= '{default: '0};
						load <= 1'b1;
						row <= '0;
						col <= '0;
						state <= S_WAIT;
					end
				end
				// Gain lands after load and the denominator one cycle later
				S_WAIT:
				begin
					load <= 1'b0;
					if (!load)
					begin
						div_start <= 1'b1;
						state <= S_DIVIDE;
					end
				end
				S_DIVIDE:
				begin
					if (div_done)
					begin
						p_out[tri_index(row, col)] <= q_sat;
						if (last_entry)
							state <= S_FINISH;
						else
						begin
							// Row by row with the column up to the diagonal
							if (col == row)
							begin
								row <= row + 1'b1;
								col <= '0;
							end
							else
								col <= col + 1'b1;
							div_start <= 1'b1;
						end
					end
				end
				S_FINISH:
				begin
					flag_out <= 1'b1;
					state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Divider results only come back during a run
	a_done_not_idle: assert property (@(posedge clk) disable iff (!rst)
		div_done |-> state != S_IDLE);

	// Denominator from the gain unit must be positive
	a_divisor_pos: assert property (@(posedge clk) disable iff (!rst)
		div_start |-> divisor > 0);

endmodule

`default_nettype wire

// File: logic/inverse_update.sv
`default_nettype none

module inverse_update
	import rls_pkg::*;
#(
	parameter int DIM = rls_pkg::DIM,
	parameter int FRAC_W = rls_pkg::FRAC_W,
	parameter int DIV_W = rls_pkg::DIV_W
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flag_in,
	input wire tri_t p_in,
	input wire vec_t x_in,
	output logic flag_out,
	output tri_t p_out
);

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Gain unit results
	gain_t gain;
	acc_t denom;

	// Sequencer to divider
	logic load;
	logic div_start;
	wide_t dividend;
	wide_t divisor;

	// Divider back to sequencer
	logic div_done;
	wide_t quotient;

	// t = P*x and d = x'*t + 1
	gain_vector #(
		.DIM (DIM),
		.FRAC_W (FRAC_W)
	) u_gain (
		.clk (clk),
		.rst (rst),
		.load (load),
		.p_in (p_in),
		.x_in (x_in),
		.gain (gain),
		.denom (denom)
	);

	// Start detect, entry stepping, result registers
	update_sequencer #(
		.DIM (DIM),
		.FRAC_W (FRAC_W)
	) u_seq (
		.clk (clk),
		.rst (rst),
		.flag_in (flag_in),
		.gain (gain),
		.denom (denom),
		.div_done (div_done),
		.quotient (quotient),
		.load (load),
		.div_start (div_start),
		.dividend (dividend),
		.divisor (divisor),
		.flag_out (flag_out),
		.p_out (p_out)
	);

	// One shared divider stepped over all entries
	seq_divider #(
		.DIV_W (DIV_W)
	) u_div (
		.clk (clk),
		.rst (rst),
		.start (div_start),
		.dividend (dividend),
		.divisor (divisor),
		.done (div_done),
		.quotient (quotient)
	);

endmodule

`default_nettype wire

// File: sim/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_elem(input string name, input elem_t got, input elem_t exp);
	if (got !== exp)
	begin
		$display("** Error: %s is %h, expected %h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1, "Element mismatch on %s", name);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("** Error: %s is %h, expected %h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1, "Flag mismatch on %s", name);
	end
endtask

// Whole triangle against expected entries
task automatic check_results(input tri_t exp);
	for (int k = 0; k < TRI; k++)
		check_elem($sformatf("p_out[%0d]", k), p_out[k], exp[k]);
endtask

//////////////////////////////
// Drive helpers
//////////////////////////////

// Operands settle while flag_in stays high
task automatic apply_inputs(input tri_t p, input vec_t x);
	@(posedge clk);
	#10;
	p_in = p;
	x_in = x;
	flag_in = 1'b1;
endtask

task automatic pulse_start();
	@(posedge clk);
	#10;
	flag_in = 1'b0;
endtask

task automatic release_flag();
	@(posedge clk);
	#10;
	flag_in = 1'b1;
endtask

// Edge detect, then flag_out low and results cleared
task automatic expect_cleared();
	tri_t zeros;
	zeros = '{default: '0};
	@(posedge clk);
	@(posedge clk);
	@(negedge clk);
	check_flag("flag_out", flag_out, 1'b0);
	check_results(zeros);
endtask

// Results held once flag_out rises, sampled mid-cycle
task automatic wait_done();
	@(posedge flag_out);
	@(negedge clk);
endtask

task automatic run_and_check(input tri_t p, input vec_t x);
	tri_t exp;
	model_update(p, x, exp);
	apply_inputs(p, x);
	pulse_start();
	wait_done();
	check_results(exp);
	release_flag();
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic test_reset_state();
	tri_t zeros;
	zeros = '{default: '0};
	@(negedge clk);
	check_flag("flag_out", flag_out, 1'b1);
	check_results(zeros);
endtask

task automatic test_identity();
	tri_t p;
	vec_t x;
	p = '{default: '0};
	for (int i = 0; i < DIM; i++)
		p[tri_index(i, i)] = to_fix(1.0);
	x = '{to_fix(0.5), to_fix(-0.25), to_fix(0.75), to_fix(1.0), to_fix(-0.5)};
	run_and_check(p, x);
endtask

// Diagonally dominant P, random x with alternating signs
task automatic test_general();
	int unsigned r;
	elem_t mag;
	gen_p = '{to_fix(4.0),
		to_fix(0.5), to_fix(3.5),
		to_fix(-0.25), to_fix(0.5), to_fix(5.0),
		to_fix(0.125), to_fix(-0.5), to_fix(0.375), to_fix(4.5),
		to_fix(-0.5), to_fix(0.25), to_fix(-0.125), to_fix(0.5), to_fix(3.0)};
	for (int i = 0; i < DIM; i++)
	begin
		r = $urandom;
		// Magnitude between 0.25 and 1.25
		mag = elem_t'(16384 + (r % 65536));
		gen_x[i] = (i % 2 == 1) ? -mag : mag;
	end
	run_and_check(gen_p, gen_x);
endtask

task automatic test_clear_restart();
	tri_t exp;
	vec_t x;
	x = '{to_fix(-1.5), to_fix(0.75), to_fix(2.0), to_fix(-0.5), to_fix(1.25)};
	model_update(gen_p, x, exp);
	apply_inputs(gen_p, x);
	pulse_start();
	expect_cleared();
	wait_done();
	check_results(exp);
	release_flag();
endtask

task automatic test_start_ignored();
	tri_t exp;
	model_update(gen_p, gen_x, exp);
	apply_inputs(gen_p, gen_x);
	pulse_start();
	expect_cleared();
	// Second falling edge while busy
	@(posedge clk);
	#10 flag_in = 1'b1;
	@(posedge clk);
	#10 flag_in = 1'b0;
	wait_done();
	check_results(exp);
	// No late restart from the ignored edge
	repeat (3)
	begin
		@(negedge clk);
		check_flag("flag_out", flag_out, 1'b1);
	end
	release_flag();
endtask

// d = 1 with large gains drives some entries past the element range
task automatic test_saturation();
	tri_t p;
	tri_t exp;
	vec_t x;
	p = '{default: '0};
	p[tri_index(1, 0)] = to_fix(1000.0);
	p[tri_index(2, 0)] = to_fix(-1000.0);
	p[tri_index(3, 0)] = to_fix(0.5);
	p[tri_index(4, 0)] = to_fix(-0.25);
	p[tri_index(4, 4)] = to_fix(2.0);
	x = '{to_fix(1.0), '0, '0, '0, '0};
	model_update(p, x, exp);
	apply_inputs(p, x);
	pulse_start();
	wait_done();
	check_elem("p_out[1,1]", p_out[tri_index(1, 1)], SAT_HI);
	check_elem("p_out[2,1]", p_out[tri_index(2, 1)], SAT_LO);
	check_elem("p_out[2,2]", p_out[tri_index(2, 2)], SAT_HI);
	check_results(exp);
	release_flag();
endtask

`endif

// File: sim/tb_inverse_update.sv
`default_nettype none

module tb_inverse_update
	import rls_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	// Watchdog budget covers eight full runs
	localparam int WATCH_CYCLES = 8 * TRI * (DIV_W + 4);

	// Output clamp limits of a Q16.16 element
	localparam elem_t SAT_HI = 32'sh7fff_ffff;
	localparam elem_t SAT_LO = 32'sh8000_0000;

	logic clk;
	logic rst;
	logic flag_in;
	tri_t p_in;
	vec_t x_in;
	logic flag_out;
	tri_t p_out;

	// Inputs of the general test, reused by later tests
	tri_t gen_p;
	vec_t gen_x;

	inverse_update #(
		.DIM (DIM),
		.FRAC_W (FRAC_W),
		.DIV_W (DIV_W)
	) dut_i (
		.clk (clk),
		.rst (rst),
		.flag_in (flag_in),
		.p_in (p_in),
		.x_in (x_in),
		.flag_out (flag_out),
		.p_out (p_out)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// t = P*x, d = x'*t + 1, then t*t'/d per lower entry
	function automatic void model_update(input tri_t p, input vec_t x, output tri_t r);
		acc_t t [DIM];
		acc_t d;
		elem_t pij;
		wide_t sum;
		wide_t num;
		wide_t q;
		for (int i = 0; i < DIM; i++)
		begin
			sum = '0;
			for (int j = 0; j < DIM; j++)
			begin
				// Mirror the upper half from the stored triangle
				pij = (j <= i) ? p[tri_index(i, j)] : p[tri_index(j, i)];
				sum = sum + wide_t'(pij) * wide_t'(x[j]);
			end
			t[i] = acc_t'(sum >>> FRAC_W);
		end
		sum = '0;
		for (int i = 0; i < DIM; i++)
			sum = sum + wide_t'(t[i]) * wide_t'(x[i]);
		d = acc_t'(sum >>> FRAC_W) + (acc_t'(1) <<< FRAC_W);
		for (int i = 0; i < DIM; i++)
		begin
			for (int j = 0; j <= i; j++)
			begin
				num = ((wide_t'(t[i]) * wide_t'(t[j])) >>> FRAC_W) <<< FRAC_W;
				// Signed divide truncates toward zero
				q = num / wide_t'(d);
				if (q > wide_t'(SAT_HI))
					r[tri_index(i, j)] = SAT_HI;
				else if (q < wide_t'(SAT_LO))
					r[tri_index(i, j)] = SAT_LO;
				else
					r[tri_index(i, j)] = elem_t'(q);
			end
		end
	endfunction

	// Real value to Q16.16
	function automatic elem_t to_fix(input real v);
		return elem_t'($rtoi(v * (2.0 ** FRAC_W)));
	endfunction

	`include "tb_tasks.svh"

	//////////////////////////////
	// Clock, watchdog, sequence
	//////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("Timeout: flag_out did not rise within %0d cycles", WATCH_CYCLES);
		$display("TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		rst = 1'b0;
		flag_in = 1'b1;
		p_in = '{default: '0};
		x_in = '{default: '0};
		void'($urandom(32'he2a7));
		// Reset held for two cycles
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b1;
		test_reset_state();
		test_identity();
		test_general();
		test_clear_restart();
		test_start_ignored();
		test_saturation();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
common/rls_pkg.sv
divider/seq_divider.sv
logic/gain_vector.sv
logic/update_sequencer.sv
logic/inverse_update.sv
sim/tb_inverse_update.sv
